// ==== logic/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// program ROM size in bytes
`define CPU_ROM_DEPTH 256

// internal RAM size in bytes
`define CPU_IRAM_DEPTH 128

`define CPU_DATA_W 8

// derived widths for PC and direct addresses
`define CPU_PC_W $clog2(`CPU_ROM_DEPTH)
`define CPU_DIR_W $clog2(`CPU_IRAM_DEPTH)

`endif

// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

	// 8051 encodings of the supported opcodes
	typedef enum logic [7:0] {
		OP_NOP      = 8'h00,
		OP_MOV_IMM  = 8'h74,
		OP_MOV_DIR  = 8'hE5,
		OP_MOV_STO  = 8'hF5,
		OP_ADD_IMM  = 8'h24,
		OP_ADD_DIR  = 8'h25,
		OP_ADDC_IMM = 8'h34,
		OP_ORL_IMM  = 8'h44,
		OP_ANL_IMM  = 8'h54,
		OP_XRL_IMM  = 8'h64,
		OP_JZ       = 8'h60,
		OP_JNZ      = 8'h70,
		OP_SJMP     = 8'h80
	} opcode_e;

	// operation applied between ACC and operand b
	typedef enum logic [2:0] {
		ALU_PASS = 3'd0,
		ALU_ADD  = 3'd1,
		ALU_ADDC = 3'd2,
		ALU_OR   = 3'd3,
		ALU_AND  = 3'd4,
		ALU_XOR  = 3'd5
	} alu_op_e;

endpackage

// ==== logic/stage_if.sv ====
`include "cpu_defines.svh"

// one decoded instruction moving between pipeline stages
interface stage_if;
	logic                   valid;
	cpu_pkg::alu_op_e       alu_op;
	// immediate or relative offset
	logic [`CPU_DATA_W-1:0] operand;
	logic [`CPU_DIR_W-1:0]  dir_addr;
	logic                   reads_mem;
	logic                   writes_mem;
	logic                   writes_acc;
	logic                   is_jz;
	logic                   is_jnz;
	// address of the following instruction
	logic [`CPU_PC_W-1:0]   next_pc;

	modport source (
		output valid, alu_op, operand, dir_addr, reads_mem, writes_mem,
		output writes_acc, is_jz, is_jnz, next_pc
	);

	modport sink (
		input valid, alu_op, operand, dir_addr, reads_mem, writes_mem,
		input writes_acc, is_jz, is_jnz, next_pc
	);
endinterface

// ==== logic/instruction_fetch.sv ====
`include "cpu_defines.svh"

module instruction_fetch (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   prog_load,
	input  logic [`CPU_PC_W-1:0]   prog_addr,
	input  logic [`CPU_DATA_W-1:0] prog_data,
	input  logic                   stall,
	input  logic                   redirect,
	input  logic [`CPU_PC_W-1:0]   redirect_pc,
	output logic [`CPU_PC_W-1:0]   fetch_pc,
	output logic [`CPU_DATA_W-1:0] ins_op,
	output logic [`CPU_DATA_W-1:0] ins_arg,
	output logic                   ins_valid
);

	logic [`CPU_DATA_W-1:0] rom [`CPU_ROM_DEPTH];
	logic [`CPU_PC_W-1:0]   arg_pc;

	// second byte of the pair, wraps at the top of the ROM
	assign arg_pc = fetch_pc + 1'b1;

	// program load port, contents survive reset
	always_ff @(posedge clk) begin
		if (prog_load)
			rom[prog_addr] <= prog_data;
	end

	// PC stays one instruction ahead of the pair register
	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_pc <= '0;
			ins_valid <= 1'b0;
		end else if (redirect) begin
			fetch_pc <= redirect_pc;
			ins_valid <= 1'b0;
		end else if (!stall) begin
			fetch_pc <= fetch_pc + `CPU_PC_W'(2);
			ins_valid <= 1'b1;
		end
	end

	// synchronous read of the opcode and operand bytes
	always_ff @(posedge clk) begin
		if (!stall) begin
			ins_op <= rom[fetch_pc];
			ins_arg <= rom[arg_pc];
		end
	end

	a_load_in_reset: assert property (
		@(posedge clk) prog_load |-> rst
	) else $error("program load outside of reset");

endmodule

// ==== logic/decode.sv ====
`include "cpu_defines.svh"

module decode (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`CPU_PC_W-1:0]   fetch_pc,
	input  logic [`CPU_DATA_W-1:0] ins_op,
	input  logic [`CPU_DATA_W-1:0] ins_arg,
	input  logic                   ins_valid,
	input  logic                   flush,
	input  logic                   pend_valid,
	input  logic [`CPU_DIR_W-1:0]  pend_addr,
	output logic                   stall,
	output logic                   redirect,
	output logic [`CPU_PC_W-1:0]   redirect_pc,
	stage_if.source                dec_to_op
);

	cpu_pkg::alu_op_e      op;
	logic                  rd_mem;
	logic                  wr_mem;
	logic                  wr_acc;
	logic                  jz;
	logic                  jnz;
	logic                  sjmp;
	logic [`CPU_DIR_W-1:0] dir;
	logic                  hit_op;
	logic                  hit_ex;

	assign dir = ins_arg[`CPU_DIR_W-1:0];

	// unknown opcodes fall through as NOP
	always_comb begin
		op = cpu_pkg::ALU_PASS;
		rd_mem = 1'b0;
		wr_mem = 1'b0;
		wr_acc = 1'b0;
		jz = 1'b0;
		jnz = 1'b0;
		sjmp = 1'b0;
		case (cpu_pkg::opcode_e'(ins_op))
			cpu_pkg::OP_MOV_IMM: wr_acc = 1'b1;
			cpu_pkg::OP_MOV_DIR: begin
				rd_mem = 1'b1;
				wr_acc = 1'b1;
			end
			cpu_pkg::OP_MOV_STO: wr_mem = 1'b1;
			cpu_pkg::OP_ADD_IMM: begin
				op = cpu_pkg::ALU_ADD;
				wr_acc = 1'b1;
			end
			cpu_pkg::OP_ADD_DIR: begin
				op = cpu_pkg::ALU_ADD;
				rd_mem = 1'b1;
				wr_acc = 1'b1;
			end
			cpu_pkg::OP_ADDC_IMM: begin
				op = cpu_pkg::ALU_ADDC;
				wr_acc = 1'b1;
			end
			cpu_pkg::OP_ORL_IMM: begin
				op = cpu_pkg::ALU_OR;
				wr_acc = 1'b1;
			end
			cpu_pkg::OP_ANL_IMM: begin
				op = cpu_pkg::ALU_AND;
				wr_acc = 1'b1;
			end
			cpu_pkg::OP_XRL_IMM: begin
				op = cpu_pkg::ALU_XOR;
				wr_acc = 1'b1;
			end
			cpu_pkg::OP_JZ: jz = 1'b1;
			cpu_pkg::OP_JNZ: jnz = 1'b1;
			cpu_pkg::OP_SJMP: sjmp = 1'b1;
			default: ;
		endcase
	end

	// stores still in flight to the address this load wants
	assign hit_op = dec_to_op.valid && dec_to_op.writes_mem && dec_to_op.dir_addr == dir;
	assign hit_ex = pend_valid && pend_addr == dir;
	assign stall = ins_valid && !flush && rd_mem && (hit_op || hit_ex);

	// fetch_pc already points past this instruction
	assign redirect = ins_valid && !flush && sjmp;
	assign redirect_pc = fetch_pc + ins_arg;

	// SJMP is resolved here and leaves a bubble
	always_ff @(posedge clk) begin
		if (rst)
			dec_to_op.valid <= 1'b0;
		else
			dec_to_op.valid <= ins_valid && !flush && !sjmp;
	end

	always_ff @(posedge clk) begin
		dec_to_op.alu_op <= op;
		dec_to_op.operand <= ins_arg;
		dec_to_op.dir_addr <= dir;
		dec_to_op.reads_mem <= rd_mem;
		dec_to_op.writes_mem <= wr_mem;
		dec_to_op.writes_acc <= wr_acc;
		dec_to_op.is_jz <= jz;
		dec_to_op.is_jnz <= jnz;
		dec_to_op.next_pc <= fetch_pc;
	end

	// a stalled load must still be here next cycle
	a_stall_holds_word: assert property (
		@(posedge clk) disable iff (rst) stall |=> $stable(ins_op) && $stable(ins_arg)
	) else $error("decode word changed while stalled");

endmodule

// ==== logic/operand_fetch.sv ====
`include "cpu_defines.svh"

module operand_fetch (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  flush,
	input  logic                  stall,
	stage_if.sink                 dec_to_op,
	stage_if.source               op_to_ex,
	output logic                  rd_en,
	output logic [`CPU_DIR_W-1:0] rd_addr
);

	logic stall_q;
	logic live;

	// a word registered while decode was stalled is a copy, drop it
	assign live = dec_to_op.valid && !stall_q;

	// read issued now, data lines up with execute next cycle
	assign rd_en = live && dec_to_op.reads_mem;
	assign rd_addr = dec_to_op.dir_addr;

	always_ff @(posedge clk) begin
		if (rst) begin
			stall_q <= 1'b0;
			op_to_ex.valid <= 1'b0;
		end else begin
			stall_q <= stall;
			op_to_ex.valid <= live && !flush;
		end
	end

	// immediates and control bits pass straight on
	always_ff @(posedge clk) begin
		op_to_ex.alu_op <= dec_to_op.alu_op;
		op_to_ex.operand <= dec_to_op.operand;
		op_to_ex.dir_addr <= dec_to_op.dir_addr;
		op_to_ex.reads_mem <= dec_to_op.reads_mem;
		op_to_ex.writes_mem <= dec_to_op.writes_mem;
		op_to_ex.writes_acc <= dec_to_op.writes_acc;
		op_to_ex.is_jz <= dec_to_op.is_jz;
		op_to_ex.is_jnz <= dec_to_op.is_jnz;
		op_to_ex.next_pc <= dec_to_op.next_pc;
	end

	// the hazard stall keeps reads away from a store in execute
	a_read_after_store: assert property (
		@(posedge clk) disable iff (rst)
		rd_en |-> !(op_to_ex.valid && op_to_ex.writes_mem && op_to_ex.dir_addr == rd_addr)
	) else $error("IRAM read issued behind a store to the same address");

endmodule

// ==== logic/ram_controller.sv ====
`include "cpu_defines.svh"

module ram_controller (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   rd_en,
	input  logic [`CPU_DIR_W-1:0]  rd_addr,
	output logic [`CPU_DATA_W-1:0] rd_data,
	input  logic                   wr_en,
	input  logic [`CPU_DIR_W-1:0]  wr_addr,
	input  logic [`CPU_DATA_W-1:0] wr_data
);

	logic [`CPU_DATA_W-1:0] mem [`CPU_IRAM_DEPTH];
	logic                   bypass;

	// write and read on the same address in one cycle
	assign bypass = wr_en && wr_addr == rd_addr;

	// whole IRAM clears in the first reset cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_IRAM_DEPTH; i++)
				mem[i] <= '0;
		end else if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// registered read port, new data wins on a collision
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= bypass ? wr_data : mem[rd_addr];
	end

endmodule

// ==== logic/alu.sv ====
`include "cpu_defines.svh"

module alu (
	input  logic                   clk,
	input  logic                   rst,
	stage_if.sink                  op_to_ex,
	input  logic [`CPU_DATA_W-1:0] rd_data,
	output logic [`CPU_DATA_W-1:0] acc,
	output logic                   flush,
	output logic                   redirect,
	output logic [`CPU_PC_W-1:0]   redirect_pc,
	output logic                   wr_en,
	output logic [`CPU_DIR_W-1:0]  wr_addr,
	output logic [`CPU_DATA_W-1:0] wr_data,
	output logic                   pend_valid,
	output logic [`CPU_DIR_W-1:0]  pend_addr
);

	logic [`CPU_DATA_W-1:0] b;
	logic [`CPU_DATA_W-1:0] result;
	logic [`CPU_DATA_W:0]   sum;
	logic                   carry;
	logic                   cin;
	logic                   is_add;
	logic                   taken;
	logic                   store;

	assign b = op_to_ex.reads_mem ? rd_data : op_to_ex.operand;
	assign cin = op_to_ex.alu_op == cpu_pkg::ALU_ADDC && carry;
	assign sum = {1'b0, acc} + {1'b0, b} + {{`CPU_DATA_W{1'b0}}, cin};
	assign is_add = op_to_ex.alu_op inside {cpu_pkg::ALU_ADD, cpu_pkg::ALU_ADDC};

	always_comb begin
		case (op_to_ex.alu_op)
			cpu_pkg::ALU_ADD,
			cpu_pkg::ALU_ADDC: result = sum[`CPU_DATA_W-1:0];
			cpu_pkg::ALU_OR:   result = acc | b;
			cpu_pkg::ALU_AND:  result = acc & b;
			cpu_pkg::ALU_XOR:  result = acc ^ b;
			default:           result = b;
		endcase
	end

	// branch test uses ACC as left by the previous instruction
	assign taken = op_to_ex.valid &&
		((op_to_ex.is_jz && acc == '0) || (op_to_ex.is_jnz && acc != '0));
	assign flush = taken;
	assign redirect = taken;
	assign redirect_pc = op_to_ex.next_pc + op_to_ex.operand;

	// store in execute takes precedence, the older strobe lands this edge
	assign store = op_to_ex.valid && op_to_ex.writes_mem;
	assign pend_valid = store || wr_en;
	assign pend_addr = store ? op_to_ex.dir_addr : wr_addr;

	always_ff @(posedge clk) begin
		if (rst) begin
			acc <= '0;
			carry <= 1'b0;
			wr_en <= 1'b0;
		end else begin
			wr_en <= store;
			if (op_to_ex.valid && op_to_ex.writes_acc) begin
				acc <= result;
				if (is_add)
					carry <= sum[`CPU_DATA_W];
			end
		end
	end

	always_ff @(posedge clk) begin
		wr_addr <= op_to_ex.dir_addr;
		wr_data <= acc;
	end

	a_flush_empties_execute: assert property (
		@(posedge clk) disable iff (rst) flush |-> redirect ##1 !op_to_ex.valid
	) else $error("taken branch left a younger instruction in execute");

endmodule

// ==== logic/cpu_top.sv ====
`include "cpu_defines.svh"

module cpu_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   prog_load,
	input  logic [`CPU_PC_W-1:0]   prog_addr,
	input  logic [`CPU_DATA_W-1:0] prog_data,
	output logic [`CPU_DATA_W-1:0] acc,
	output logic                   ram_write,
	output logic [`CPU_DIR_W-1:0]  ram_write_addr,
	output logic [`CPU_DATA_W-1:0] ram_write_data
);

	logic [`CPU_PC_W-1:0]   fetch_pc;
	logic [`CPU_DATA_W-1:0] ins_op;
	logic [`CPU_DATA_W-1:0] ins_arg;
	logic                   ins_valid;
	logic                   stall;
	logic                   flush;
	logic                   redirect;
	logic [`CPU_PC_W-1:0]   redirect_pc;
	logic                   dec_redirect;
	logic [`CPU_PC_W-1:0]   dec_redirect_pc;
	logic                   alu_redirect;
	logic [`CPU_PC_W-1:0]   alu_redirect_pc;
	logic                   rd_en;
	logic [`CPU_DIR_W-1:0]  rd_addr;
	logic [`CPU_DATA_W-1:0] rd_data;
	logic                   wr_en;
	logic [`CPU_DIR_W-1:0]  wr_addr;
	logic [`CPU_DATA_W-1:0] wr_data;
	logic                   pend_valid;
	logic [`CPU_DIR_W-1:0]  pend_addr;

	stage_if dec_to_op ();
	stage_if op_to_ex ();

	// the alu branch is older than any SJMP in decode
	assign redirect = alu_redirect || dec_redirect;
	assign redirect_pc = alu_redirect ? alu_redirect_pc : dec_redirect_pc;

	assign ram_write = wr_en;
	assign ram_write_addr = wr_addr;
	assign ram_write_data = wr_data;

	instruction_fetch u_fetch (
		.clk(clk), .rst(rst),
		.prog_load(prog_load), .prog_addr(prog_addr), .prog_data(prog_data),
		.stall(stall), .redirect(redirect), .redirect_pc(redirect_pc),
		.fetch_pc(fetch_pc), .ins_op(ins_op), .ins_arg(ins_arg), .ins_valid(ins_valid)
	);

	decode u_decode (
		.clk(clk), .rst(rst), .fetch_pc(fetch_pc),
		.ins_op(ins_op), .ins_arg(ins_arg), .ins_valid(ins_valid), .flush(flush),
		.pend_valid(pend_valid), .pend_addr(pend_addr),
		.stall(stall), .redirect(dec_redirect), .redirect_pc(dec_redirect_pc),
		.dec_to_op(dec_to_op)
	);

	operand_fetch u_operand (
		.clk(clk), .rst(rst), .flush(flush), .stall(stall),
		.dec_to_op(dec_to_op), .op_to_ex(op_to_ex),
		.rd_en(rd_en), .rd_addr(rd_addr)
	);

	ram_controller u_ram (
		.clk(clk), .rst(rst),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
	);

	alu u_alu (
		.clk(clk), .rst(rst), .op_to_ex(op_to_ex), .rd_data(rd_data), .acc(acc),
		.flush(flush), .redirect(alu_redirect), .redirect_pc(alu_redirect_pc),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.pend_valid(pend_valid), .pend_addr(pend_addr)
	);

endmodule

// ==== tb/cpu_checker.sv ====
module cpu_checker (
	input  logic       clk,
	input  logic       rst,
	input  logic       prog_load,
	input  logic [7:0] prog_addr,
	input  logic [7:0] prog_data,
	input  logic [7:0] acc,
	input  logic       ram_write,
	input  logic [6:0] ram_write_addr,
	input  logic [7:0] ram_write_data,
	output logic       done,
	output int         errors
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [7:0] rom [256];
	logic [7:0] iram [128];
	logic [7:0] pc;
	logic [7:0] m_acc;
	logic       carry;
	bit         found;
	logic [6:0] exp_addr;
	logic [7:0] exp_data;

	// step the instruction-set model up to its next store
	task automatic run_to_store();
		logic [7:0] op;
		logic [7:0] arg;
		logic [7:0] b;
		logic [8:0] sum;
		found = 1'b0;
		// closing SJMP loops without a store, hence the bound
		for (int n = 0; n < 512 && !found; n++) begin
			op = rom[pc];
			arg = rom[pc + 8'd1];
			pc = pc + 8'd2;
			b = (op == 8'h25) ? iram[arg[6:0]] : arg;
			sum = {1'b0, m_acc} + {1'b0, b} + {8'd0, op == 8'h34 && carry};
			case (op)
				8'h74: m_acc = arg;
				8'hE5: m_acc = iram[arg[6:0]];
				8'hF5: begin
					iram[arg[6:0]] = m_acc;
					exp_addr = arg[6:0];
					exp_data = m_acc;
					found = 1'b1;
				end
				8'h24, 8'h25, 8'h34: begin
					m_acc = sum[7:0];
					carry = sum[8];
				end
				8'h44: m_acc = m_acc | arg;
				8'h54: m_acc = m_acc & arg;
				8'h64: m_acc = m_acc ^ arg;
				// offsets count from the next instruction
				8'h60: if (m_acc == 8'h00) pc = pc + arg;
				8'h70: if (m_acc != 8'h00) pc = pc + arg;
				8'h80: pc = pc + arg;
				default: ;
			endcase
		end
	endtask

	initial begin
		done = 1'b0;
		errors = 0;
	end

	// outputs sampled mid-cycle where they are stable
	always @(negedge clk) begin
		if (prog_load)
			rom[prog_addr] = prog_data;
		if (rst) begin
			pc = 8'h00;
			m_acc = 8'h00;
			carry = 1'b0;
			done = 1'b0;
			for (int i = 0; i < 128; i++)
				iram[i] = 8'h00;
		end else if (ram_write === 1'b1) begin
			run_to_store();
			if (!found) begin
				errors++;
				$display("[FAIL] %0t: store of %h to %h where the model has none",
					$time, ram_write_data, ram_write_addr);
			end else if (ram_write_addr !== exp_addr || ram_write_data !== exp_data) begin
				errors++;
				$display("[FAIL] %0t: store expected %h to %h, got %h to %h",
					$time, exp_data, exp_addr, ram_write_data, ram_write_addr);
			end
			// marker store at 7F ends the program
			if (ram_write_addr == 7'h7F) begin
				if (acc !== m_acc) begin
					errors++;
					$display("[FAIL] %0t: final acc expected %h, got %h", $time, m_acc, acc);
				end
				done = 1'b1;
			end
		end
	end

endmodule

// ==== tb/cpu_tb.sv ====
module cpu_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic       clk;
	logic       rst;
	logic       prog_load;
	logic [7:0] prog_addr;
	logic [7:0] prog_data;
	logic [7:0] acc;
	logic       ram_write;
	logic [6:0] ram_write_addr;
	logic [7:0] ram_write_data;
	logic       done;
	int         errors;

	int         seed;
	int         first_seed;
	logic [7:0] prog [256];
	int         prog_len;
	int         pass_count;
	int         fail_count;
	bit         timed_out;

	cpu_top u_cpu_top (.*);
	cpu_checker u_checker (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic int rand_below(input int n);
		return {$random(seed)} % n;
	endfunction

	task automatic emit(input logic [7:0] op, input logic [7:0] arg);
		prog[prog_len] = op;
		prog[prog_len + 1] = arg;
		prog_len += 2;
	endtask

	// JZ, JNZ or SJMP forward, never beyond the marker store
	task automatic emit_branch(input int left);
		int skip;
		skip = rand_below(4);
		emit(8'h60 + 8'(16 * rand_below(3)), 8'(2 * (skip < left ? skip : left)));
	endtask

	task automatic gen_program(input int kind, input int count);
		logic [7:0] dir;
		prog_len = 0;
		for (int i = 0; i < count; i++) begin
			// hazard program crowds into 30..33
			dir = 8'h30 + 8'(rand_below(4));
			case (kind)
				// 24, 34 .. 74 are the immediate ops
				1: begin
					emit(8'h24 + 8'(16 * rand_below(6)), 8'(rand_below(256)));
					if (i % 5 == 4)
						emit(8'hF5, 8'(rand_below(127)));
				end
				2: case (rand_below(4))
					0: emit(8'h74, 8'(rand_below(256)));
					1: emit(8'hF5, dir);
					2: emit(8'hE5, dir);
					default: emit(8'h25, dir);
				endcase
				3: case (i % 3)
					0: emit(8'h74, rand_below(2) ? 8'h00 : 8'(rand_below(256)));
					1: emit_branch(count - 1 - i);
					default: emit(8'hF5, 8'(rand_below(127)));
				endcase
				default: case (rand_below(10))
					0: emit(8'h00, 8'(rand_below(256)));
					1: emit(8'hE5, 8'(rand_below(128)));
					2: emit(8'hF5, 8'(rand_below(127)));
					3: emit(8'h25, 8'(rand_below(128)));
					4: emit_branch(count - 1 - i);
					// x1 opcodes are outside the set
					5: emit({4'(rand_below(16)), 4'h1}, 8'(rand_below(256)));
					default: emit(8'h24 + 8'(16 * rand_below(6)), 8'(rand_below(256)));
				endcase
			endcase
		end
		// marker store, then SJMP to itself
		emit(8'hF5, 8'h7F);
		emit(8'h80, 8'hFE);
	endtask

	task automatic run_test(input string name, input int abort_after);
		int limit;
		int cycles;
		int err_start;
		if (timed_out)
			return;
		err_start = errors;
		// one ROM byte per cycle while reset is held
		@(posedge clk);
		#2;
		rst = 1'b1;
		for (int i = 0; i < prog_len; i++) begin
			prog_load = 1'b1;
			prog_addr = 8'(i);
			prog_data = prog[i];
			@(posedge clk);
			#2;
		end
		prog_load = 1'b0;
		rst = 1'b0;
		if (abort_after > 0) begin
			// second reset, ROM contents kept
			repeat (abort_after) @(posedge clk);
			#2;
			rst = 1'b1;
			repeat (2) @(posedge clk);
			#2;
			rst = 1'b0;
		end
		limit = 8 * (prog_len / 2) + 50;
		cycles = 0;
		while (!done && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (!done) begin
			$display("test %s stalled with no marker store after %0d cycles", name, limit);
			timed_out = 1'b1;
			fail_count++;
		end else if (errors != err_start) begin
			$display("FAIL %s with %0d mismatches", name, errors - err_start);
			fail_count++;
		end else begin
			$display("PASS %s", name);
			pass_count++;
		end
	endtask

	initial begin
		rst = 1'b1;
		prog_load = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		seed = 32'hd5fa_f2da;
		pass_count = 0;
		fail_count = 0;
		timed_out = 1'b0;
		repeat (2) @(posedge clk);
		first_seed = seed;
		gen_program(1, 40);
		run_test("immediate arithmetic", 0);
		gen_program(2, 40);
		run_test("memory hazards", 0);
		gen_program(3, 36);
		run_test("branches", 0);
		// same program as the first test
		seed = first_seed;
		gen_program(1, 40);
		run_test("reset mid-run", 20);
		gen_program(5, 60);
		run_test("mixed", 0);
		$display("%0d tests passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/stage_if.sv
logic/instruction_fetch.sv
logic/decode.sv
logic/operand_fetch.sv
logic/ram_controller.sv
logic/alu.sv
logic/cpu_top.sv
tb/cpu_checker.sv
tb/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: pipe8051

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpu_pkg.sv
      - logic/stage_if.sv
      - logic/instruction_fetch.sv
      - logic/decode.sv
      - logic/operand_fetch.sv
      - logic/ram_controller.sv
      - logic/alu.sv
      - logic/cpu_top.sv
  - target: test
    files:
      - tb/cpu_checker.sv
      - tb/cpu_tb.sv
